// File: rv_core.f
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_core.sv
tb/rv_core_assertions.sv
tb/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_core_pkg.sv
      - hdl/rv_decoder.sv
      - hdl/rv_regfile.sv
      - hdl/rv_execute.sv
      - hdl/rv_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/rv_core_assertions.sv
      - tb/rv_core_tb.sv

// File: tb/rv_core_tb.sv
// Testbench for the RV32I core with a random program, fetch and data memories and a register model
// Checks every write-back and store against the model and counts load-use stall cycles
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int PROG_LEN = 200;
    localparam int MAX_CYCLES = 2 * PROG_LEN + 40;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } reg_write_t;

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
    } store_t;

    logic                   clk;
    logic                   rst;
    logic [`XLEN-1:0]       instruction;
    logic [`XLEN-1:0]       d_rdata;
    logic [`XLEN-1:0]       pc;
    logic                   fetch_en;
    logic [`XLEN-1:0]       d_addr;
    logic [`XLEN-1:0]       d_wdata;
    logic                   mem_read;
    logic                   mem_write;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;

    logic [`XLEN-1:0] imem [0:PROG_LEN-1];
    logic [`XLEN-1:0] data_mem [0:63];
    logic [`XLEN-1:0] ref_mem [0:63];
    logic [`XLEN-1:0] ref_regs [0:7];
    reg_write_t       wb_expect [$];
    store_t           store_expect [$];
    logic [31:0]      seed = 32'h7e89;
    int               errors = 0;
    int               stalls_seen = 0;
    int               stalls_expected = 0;
    int               cycles = 0;

    rv_core dut (.*);

    always #10 clk = ~clk;

    // Fetch memory answers one cycle later and holds its word while fetch_en is low
    always @(posedge clk)
    begin
        if (rst)
            instruction <= '0;
        else if (fetch_en)
            instruction <= fetch_word(pc);
    end

    always @(posedge clk)
    begin
        if (!rst && mem_write)
            data_mem[d_addr[7:2]] <= d_wdata;
        if (!rst && mem_read)
            d_rdata <= data_mem[d_addr[7:2]];
    end

    always @(negedge clk)
    begin
        if (rst === 1'b0)
        begin
            if (wb_valid)
                check_writeback();
            if (mem_write)
                check_store();
            if (!fetch_en)
                stalls_seen++;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [`XLEN-1:0] fill_word(input int idx);
        return 32'(idx) * 32'h9e37_79b9 ^ 32'hc3a5_0f1e;
    endfunction

    // Past the end of the program the memory returns bubbles
    function automatic logic [`XLEN-1:0] fetch_word(input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] index;
        index = (addr - `RESET_PC) >> 2;
        if (index < PROG_LEN)
            return imem[index];
        return '0;
    endfunction

    // RV32I integer result by funct3 where alt selects SUB and SRA
    function automatic logic [`XLEN-1:0] alu_result(input logic [2:0] f3, input logic alt,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic set_reg(input logic [4:0] rd, input logic [`XLEN-1:0] value);
        reg_write_t w;
        if (rd != '0)
        begin
            ref_regs[rd] = value;
            w.rd = rd;
            w.data = value;
            wb_expect.push_back(w);
        end
    endtask

    // Kinds 0-4 R-type, 5-8 I-type, 9 LUI, 10-12 LW, 13-15 SW
    task automatic build_program();
        logic [31:0] r;
        logic [31:0] s;
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev_rd;
        logic [4:0]  load_rd;
        logic [11:0] imm;
        logic [5:0]  idx;
        logic        reads_rs1;
        logic        reads_rs2;
        store_t      st;
        prev_rd = '0;
        load_rd = '0;
        for (int i = 0; i < PROG_LEN; i++)
        begin
            r = next_rand();
            s = next_rand();
            kind = r[31:28];
            rd = {2'b00, r[27:25]};
            rs1 = (s[13:12] == 2'b00) ? prev_rd : {2'b00, r[24:22]};
            rs2 = (s[11:10] == 2'b00) ? prev_rd : {2'b00, r[21:19]};
            f3 = 3'(r[18:16] % 7);
            if (f3 >= 3'd3)
                f3 = f3 + 3'd1;
            alt = r[15];
            idx = s[19:14];
            // Prologue gives x1 to x7 known values with ADDI from x0
            if (i < 7)
            begin
                kind = 4'd5;
                f3 = 3'd0;
                rd = 5'(i + 1);
                rs1 = '0;
            end
            reads_rs1 = kind <= 4'd8;
            reads_rs2 = kind <= 4'd4 || kind >= 4'd13;
            if (kind <= 4'd4)
            begin
                alt = alt && (f3 == 3'd0 || f3 == 3'd5);
                imem[i] = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
                set_reg(rd, alu_result(f3, alt, ref_regs[rs1], ref_regs[rs2]));
            end
            else if (kind <= 4'd8)
            begin
                alt = alt && f3 == 3'd5;
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm = {1'b0, alt, 5'b0, s[24:20]};
                else
                    imm = s[31:20];
                imem[i] = {imm, rs1, f3, rd, OPC_OP_IMM};
                set_reg(rd, alu_result(f3, alt, ref_regs[rs1], {{20{imm[11]}}, imm}));
            end
            else if (kind == 4'd9)
            begin
                imem[i] = {s[31:12], rd, OPC_LUI};
                set_reg(rd, {s[31:12], 12'b0});
            end
            else if (kind <= 4'd12)
            begin
                imm = {4'b0, idx, 2'b00};
                imem[i] = {imm, 5'd0, 3'b010, rd, OPC_LOAD};
                set_reg(rd, ref_mem[idx]);
            end
            else
            begin
                imm = {4'b0, idx, 2'b00};
                imem[i] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OPC_STORE};
                ref_mem[idx] = ref_regs[rs2];
                st.addr = 32'(imm);
                st.data = ref_regs[rs2];
                store_expect.push_back(st);
            end
            // A load feeding the very next instruction costs one stall cycle
            if (load_rd != '0 && ((reads_rs1 && rs1 == load_rd) ||
                                  (reads_rs2 && rs2 == load_rd)))
                stalls_expected++;
            load_rd = (kind >= 4'd10 && kind <= 4'd12) ? rd : 5'd0;
            if (kind <= 4'd12)
                prev_rd = rd;
        end
    endtask

    task automatic check_writeback();
        reg_write_t exp;
        if (wb_expect.size() == 0)
        begin
            $display("Register write to x%0d at %0t ns after the program retired", wb_rd, $time);
            errors++;
        end
        else
        begin
            exp = wb_expect.pop_front();
            assert (wb_rd === exp.rd)
            else
                report_mismatch("wb_rd", 32'(exp.rd), 32'(wb_rd));
            assert (wb_data === exp.data)
            else
                report_mismatch("wb_data", exp.data, wb_data);
        end
    endtask

    task automatic check_store();
        store_t exp;
        if (store_expect.size() == 0)
        begin
            $display("Store strobe at %0t ns with no store left in the program", $time);
            errors++;
        end
        else
        begin
            exp = store_expect.pop_front();
            assert (d_addr === exp.addr)
            else
                report_mismatch("d_addr", exp.addr, d_addr);
            assert (d_wdata === exp.data)
            else
                report_mismatch("d_wdata", exp.data, d_wdata);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        instruction = '0;
        d_rdata = '0;
        for (int i = 0; i < 64; i++)
        begin
            data_mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 8; i++)
            ref_regs[i] = '0;
        build_program();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while ((wb_expect.size() != 0 || store_expect.size() != 0) && cycles < MAX_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        if (wb_expect.size() != 0 || store_expect.size() != 0)
        begin
            $display("Timeout after %0d cycles, the program did not retire", cycles);
            errors++;
        end
        // A few more cycles catch stray writes after the last instruction
        repeat (8) @(posedge clk);
        assert (stalls_seen == stalls_expected)
        else
            report_mismatch("fetch_en stall cycles", stalls_expected, stalls_seen);
        $display("Errors: %0d value, %0d assertion, %0d cycles run", errors,
                 dut.u_assertions.failures, cycles);
        if (errors == 0 && dut.u_assertions.failures == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: tb/rv_core_assertions.sv
// Concurrent protocol checks for the core, bound into every rv_core instance
// Covers reset state, load-use stall shape and write-back and data strobe rules
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic [`XLEN-1:0]       pc,
    input logic                   fetch_en,
    input logic                   mem_read,
    input logic                   mem_write,
    input logic                   wb_valid,
    input logic [`REG_ADDR_W-1:0] wb_rd
);
    int failures = 0;

    // A stall lasts one cycle, holds the PC and comes from a load now in memory stage
    stall_one_cycle: assert property (@(posedge clk) disable iff (rst) !fetch_en |=> fetch_en)
    else
    begin
        failures = failures + 1;
        $error("fetch_en low for more than one cycle");
    end

    stall_holds_pc: assert property (@(posedge clk) disable iff (rst)
        !fetch_en |=> pc == $past(pc))
    else
    begin
        failures = failures + 1;
        $error("pc moved during a stall cycle");
    end

    stall_from_load: assert property (@(posedge clk) disable iff (rst) !fetch_en |=> mem_read)
    else
    begin
        failures = failures + 1;
        $error("stall not followed by a load in the memory stage");
    end

    // Reset state, first instruction reaches memory stage 3 cycles later
    reset_pc: assert property (@(posedge clk) $fell(rst) |-> pc == `RESET_PC && fetch_en)
    else
    begin
        failures = failures + 1;
        $error("pc or fetch_en wrong after reset");
    end

    reset_mem_quiet: assert property (@(posedge clk)
        $fell(rst) |-> (!mem_read && !mem_write)[*3])
    else
    begin
        failures = failures + 1;
        $error("data strobe before the first instruction reached memory stage");
    end

    reset_wb_quiet: assert property (@(posedge clk) $fell(rst) |-> (!wb_valid)[*4])
    else
    begin
        failures = failures + 1;
        $error("wb_valid before the first instruction reached write-back");
    end

    read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write))
    else
    begin
        failures = failures + 1;
        $error("mem_read and mem_write high together");
    end

    // x0 is never a write-back target
    no_x0_write: assert property (@(posedge clk) disable iff (rst) wb_valid |-> wb_rd != '0)
    else
    begin
        failures = failures + 1;
        $error("wb_valid with wb_rd equal to x0");
    end

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clk      (clk),
    .rst      (rst),
    .pc       (pc),
    .fetch_en (fetch_en),
    .mem_read (mem_read),
    .mem_write(mem_write),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd)
);

// File: hdl/rv_core.sv
// Five-stage RV32I core top: PC, stage registers, load-use stall, write-back select
// Fetch memory answers one cycle after pc, data memory reads land in write-back
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`XLEN-1:0]       instruction,
    input  logic [`XLEN-1:0]       d_rdata,
    output logic [`XLEN-1:0]       pc,
    output logic                   fetch_en,
    output logic [`XLEN-1:0]       d_addr,
    output logic [`XLEN-1:0]       d_wdata,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data
);
    import rv_core_pkg::*;

    logic             instr_valid;
    logic             load_use;
    dec_t             dec;
    dec_t             id_dec;
    dec_t             id_ex;
    ex_mem_t          ex_out;
    ex_mem_t          mem_q;
    ex_mem_t          wb_q;
    logic [`XLEN-1:0] rf_a;
    logic [`XLEN-1:0] rf_b;

    // The word on instruction is not a fetched one in the first cycle after reset
    always_ff @(posedge clk)
    begin
        if (rst)
            instr_valid <= 1'b0;
        else
            instr_valid <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= `RESET_PC;
        else if (fetch_en)
            pc <= pc + `INSTR_BYTES;
    end

    rv_decoder u_decoder (
        .instruction (instruction),
        .dec         (dec)
    );

    assign id_dec = instr_valid ? dec : '0;

    // Load in execute feeding the decoding instruction, hold fetch one cycle
    assign load_use = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
                      (id_ex.rd == id_dec.rs1 || id_ex.rd == id_dec.rs2);
    assign fetch_en = !load_use;

    rv_regfile u_regfile (
        .clk       (clk),
        .wr_en     (wb_q.reg_write),
        .wr_addr   (wb_q.rd),
        .wr_data   (wb_data),
        .rd_addr_a (id_dec.rs1),
        .rd_addr_b (id_dec.rs2),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b)
    );

    // Stall inserts a bubble by clearing the control word
    always_ff @(posedge clk)
    begin
        id_ex <= id_dec;
        if (rst || load_use)
            id_ex.ctrl <= '0;
    end

    rv_execute u_execute (
        .id_ex    (id_ex),
        .op_a     (rf_a),
        .op_b     (rf_b),
        .mem_fwd  (mem_q),
        .wb_rd    (wb_q.rd),
        .wb_write (wb_q.reg_write),
        .wb_value (wb_data),
        .ex_mem   (ex_out)
    );

    always_ff @(posedge clk)
    begin
        mem_q <= ex_out;
        wb_q <= mem_q;
        if (rst)
        begin
            mem_q.reg_write <= 1'b0;
            mem_q.mem_read <= 1'b0;
            mem_q.mem_write <= 1'b0;
            wb_q.reg_write <= 1'b0;
        end
    end

    assign d_addr = mem_q.result;
    assign d_wdata = mem_q.store_data;
    assign mem_read = mem_q.mem_read;
    assign mem_write = mem_q.mem_write;

    // Load data arrives during write-back
    assign wb_data = wb_q.mem_to_reg ? d_rdata : wb_q.result;
    assign wb_rd = wb_q.rd;
    assign wb_valid = wb_q.reg_write && wb_q.rd != '0;

endmodule

// File: hdl/rv_execute.sv
// Execute stage: operand forwarding, operand B select and the ALU
// Purely combinational, the result is registered in the core's memory stage
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_execute (
    input  rv_core_pkg::dec_t      id_ex,
    input  logic [`XLEN-1:0]       op_a,
    input  logic [`XLEN-1:0]       op_b,
    input  rv_core_pkg::ex_mem_t   mem_fwd,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic                   wb_write,
    input  logic [`XLEN-1:0]       wb_value,
    output rv_core_pkg::ex_mem_t   ex_mem
);
    import rv_core_pkg::*;

    logic [`XLEN-1:0] fwd_a;
    logic [`XLEN-1:0] fwd_b;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_y;
    logic [4:0]       shamt;

    // Memory stage has the newer value, so it is checked first
    function automatic logic [`XLEN-1:0] forward(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`XLEN-1:0]       reg_val
    );
        if (mem_fwd.reg_write && mem_fwd.rd != '0 && mem_fwd.rd == rs)
            return mem_fwd.result;
        else if (wb_write && wb_rd != '0 && wb_rd == rs)
            return wb_value;
        return reg_val;
    endfunction

    always_comb
    begin
        fwd_a = forward(id_ex.rs1, op_a);
        fwd_b = forward(id_ex.rs2, op_b);
        alu_b = id_ex.ctrl.use_imm ? id_ex.imm : fwd_b;
    end

    assign shamt = alu_b[4:0];

    always_comb
    begin
        case (id_ex.ctrl.alu_op)
            ALU_AND: alu_y = fwd_a & alu_b;
            ALU_OR:  alu_y = fwd_a | alu_b;
            ALU_ADD: alu_y = fwd_a + alu_b;
            ALU_SUB: alu_y = fwd_a - alu_b;
            ALU_SLT: alu_y = {{(`XLEN-1){1'b0}}, $signed(fwd_a) < $signed(alu_b)};
            ALU_XOR: alu_y = fwd_a ^ alu_b;
            ALU_SRL: alu_y = fwd_a >> shamt;
            ALU_SLL: alu_y = fwd_a << shamt;
            ALU_SRA: alu_y = $unsigned($signed(fwd_a) >>> shamt);
            default: alu_y = fwd_a + alu_b;
        endcase
    end

    // Store data is the forwarded rs2, never the immediate
    always_comb
    begin
        ex_mem.reg_write = id_ex.ctrl.reg_write;
        ex_mem.mem_read = id_ex.ctrl.mem_read;
        ex_mem.mem_write = id_ex.ctrl.mem_write;
        ex_mem.mem_to_reg = id_ex.ctrl.mem_to_reg;
        ex_mem.rd = id_ex.rd;
        ex_mem.result = alu_y;
        ex_mem.store_data = fwd_b;
    end

endmodule

// File: hdl/rv_regfile.sv
// 32-entry register file with registered reads and write-through
// x0 has no storage and always reads as zero
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_regfile (
    input  logic                   clk,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`XLEN-1:0]       wr_data,
    input  logic [`REG_ADDR_W-1:0] rd_addr_a,
    input  logic [`REG_ADDR_W-1:0] rd_addr_b,
    output logic [`XLEN-1:0]       rd_data_a,
    output logic [`XLEN-1:0]       rd_data_b
);
    logic [`XLEN-1:0] regs [1:(1 << `REG_ADDR_W) - 1];

    // Same-cycle write to the read index wins over the stored value
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        else if (wr_en && wr_addr == addr)
            return wr_data;
        return regs[addr];
    endfunction

    always_ff @(posedge clk)
    begin
        if (wr_en && wr_addr != '0)
            regs[wr_addr] <= wr_data;
        rd_data_a <= read_port(rd_addr_a);
        rd_data_b <= read_port(rd_addr_b);
    end

endmodule

// File: hdl/rv_decoder.sv
// Combinational decoder for the RV32I subset of the core
// Turns a fetched word into control bits, register indices and one selected immediate
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_decoder (
    input  logic [`XLEN-1:0] instruction,
    output rv_core_pkg::dec_t dec
);
    import rv_core_pkg::*;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    alu_op_e          alu_fn;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_u;

    assign opcode = opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // Sign-extended I and S immediates, U is the upper 20 bits
    assign imm_i = {{(`XLEN-12){instruction[31]}}, instruction[31:20]};
    assign imm_s = {{(`XLEN-12){instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_u = {instruction[31:12], 12'b0};

    // ALU function from funct3, funct7 bit 5 picks SUB and SRA
    always_comb
    begin
        case (funct3)
            3'b000: alu_fn = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001: alu_fn = ALU_SLL;
            3'b010: alu_fn = ALU_SLT;
            3'b100: alu_fn = ALU_XOR;
            3'b101: alu_fn = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110: alu_fn = ALU_OR;
            3'b111: alu_fn = ALU_AND;
            default: alu_fn = ALU_ADD;
        endcase
    end

    // Unused source fields stay at x0 so hazard checks see no false match
    always_comb
    begin
        dec = '0;
        dec.ctrl.alu_op = ALU_ADD;
        case (opcode)
            OPC_OP:
            begin
                dec.rs1 = instruction[19:15];
                dec.rs2 = instruction[24:20];
                dec.rd = instruction[11:7];
                dec.ctrl.alu_op = alu_fn;
                dec.ctrl.reg_write = 1'b1;
            end
            OPC_OP_IMM:
            begin
                dec.rs1 = instruction[19:15];
                dec.rd = instruction[11:7];
                dec.imm = imm_i;
                dec.ctrl.alu_op = alu_fn;
                dec.ctrl.use_imm = 1'b1;
                dec.ctrl.reg_write = 1'b1;
            end
            OPC_LOAD:
            begin
                dec.rs1 = instruction[19:15];
                dec.rd = instruction[11:7];
                dec.imm = imm_i;
                dec.ctrl.use_imm = 1'b1;
                dec.ctrl.mem_read = 1'b1;
                dec.ctrl.reg_write = 1'b1;
                dec.ctrl.mem_to_reg = 1'b1;
            end
            OPC_STORE:
            begin
                dec.rs1 = instruction[19:15];
                dec.rs2 = instruction[24:20];
                dec.imm = imm_s;
                dec.ctrl.use_imm = 1'b1;
                dec.ctrl.mem_write = 1'b1;
            end
            // LUI adds its immediate to x0
            OPC_LUI:
            begin
                dec.rd = instruction[11:7];
                dec.imm = imm_u;
                dec.ctrl.use_imm = 1'b1;
                dec.ctrl.reg_write = 1'b1;
            end
            default:
                dec.ctrl.alu_op = ALU_ADD;
        endcase
    end

endmodule

// File: hdl/rv_core_pkg.sv
// Opcode and ALU encodings plus the structs passed between pipeline stages
// Modules import this package inside their body and name its types in port lists
`include "rv_core_defines.svh"

package rv_core_pkg;

    // Major opcodes kept in this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // ALU functions
    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0011,
        ALU_SLT = 4'b0111,
        ALU_XOR = 4'b1101,
        ALU_SRL = 4'b1000,
        ALU_SLL = 4'b1001,
        ALU_SRA = 4'b1010
    } alu_op_e;

    // Control word, all enables low is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    mem_to_reg;
    } ctrl_t;

    // Decoded instruction, also the decode-to-execute register
    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`REG_ADDR_W-1:0]  rs1;
        logic [`REG_ADDR_W-1:0]  rs2;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`XLEN-1:0]        imm;
    } dec_t;

    // Execute result, reused for the memory and write-back registers
    typedef struct packed {
        logic                    reg_write;
        logic                    mem_read;
        logic                    mem_write;
        logic                    mem_to_reg;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`XLEN-1:0]        result;
        logic [`XLEN-1:0]        store_data;
    } ex_mem_t;

endpackage

// File: hdl/rv_core_defines.svh
// Width and address constants shared by the RV32I core and its testbench
// Include wherever XLEN, register index width or the reset PC are needed
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Data and address width
`define XLEN 32

// Register index width, 32 architectural registers
`define REG_ADDR_W 5

// First fetch address after reset
`define RESET_PC 32'h0040_0000

// PC step per instruction, no compressed instructions
`define INSTR_BYTES 4

`endif
